// File: build.f
pkg_extern.sv
ring_buff_ctrl.sv
extern_handle.sv
mem_access_arbiter.sv
data_mem.sv
extern_top.sv
tb_extern_top.sv

// File: data_mem.sv
/*
 * Single-port data memory
 * Synchronous write, registered read with one cycle latency
 */
`timescale 1ns/1ps
`default_nettype none

module data_mem
	import pkg_extern::*;
(
	input wire logic clock,
	input wire logic we,
	input wire address_t addr,
	input wire data_t wdata,
	output data_t rdata
);

	data_t mem [MEM_DEPTH];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];			// Old data on a write
	end

endmodule

`default_nettype wire

// File: extern_handle.sv
/*
 * External port handler
 * Decodes the three-word command, buffers store or load data
 * and requests the shared data memory through the arbiter
 */
`timescale 1ns/1ps
`default_nettype none

module extern_handle
	import pkg_extern::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire ext_in_t ext_in,
	output ext_out_t ext_out,
	output access_cmd_t cmd,
	input wire logic grant,
	input wire logic term,
	output data_t st_data,
	input wire logic ld_valid,
	input wire data_t ld_data
);

	fsm_serv_t serv_state;
	fsm_st_t   st_state;
	fsm_ld_t   ld_state;

	address_t stride_r;
	address_t length_r;
	address_t base_r;
	logic     is_load_r;

	data_t                 buff [BUFF_SIZE];
	data_t                 buff_rd;
	data_t                 buff_wdata;
	logic                  buff_we;
	logic                  buff_re;
	logic [WIDTH_BUFF-1:0] wr_ptr;
	logic [WIDTH_BUFF-1:0] rd_ptr;
	logic                  buff_full;
	logic                  buff_empty;
	logic [WIDTH_BUFF:0]   num;

	logic     abort;
	logic     cmd_strobe;
	logic     start_st;
	logic     start_ld;
	logic     st_push;
	logic     st_pop;
	logic     st_done;
	logic     ld_push;
	logic     ld_pop;
	logic     ld_last;
	logic     notify_q;
	logic     notified;
	address_t num_ext;
	address_t half_len;
	address_t ld_cnt;

	// Length kept within 1 to BUFF_SIZE
	function automatic address_t clip_length(input address_t len);
		address_t res;
		if (len == '0) begin
			res = address_t'(1);
		end
		else if (len > address_t'(BUFF_SIZE)) begin
			res = address_t'(BUFF_SIZE);
		end
		else begin
			res = len;
		end
		return res;
	endfunction

	assign abort      = ext_in.rls;
	assign cmd_strobe = ext_in.req & ~abort;
	assign start_st   = (serv_state == SERV_BASE) & cmd_strobe & ~is_load_r;
	assign start_ld   = (serv_state == SERV_BASE) & cmd_strobe & is_load_r;
	assign num_ext    = address_t'(num);
	assign half_len   = (length_r + address_t'(1)) >> 1;

	assign st_push = cmd_strobe & (st_state == ST_BUFF) & ~buff_full;
	assign st_pop  = (st_state == ST_RUN);				// One word per beat
	assign st_done = st_pop & term;
	assign ld_push = ld_valid & ((ld_state == LD_RUN) | (ld_state == LD_DRAIN));
	assign ld_pop  = ~buff_empty & ((ld_state == LD_RUN) | (ld_state == LD_DRAIN));
	assign ld_last = ld_pop & (ld_cnt == length_r - address_t'(1));

	////////////////////////////////////////
	// Buffer
	////////////////////////////////////////
	assign buff_we    = st_push | ld_push;
	assign buff_re    = st_pop | ld_pop;
	assign buff_wdata = st_push ? ext_in.data : ld_data;
	assign buff_rd    = buff[rd_ptr];

	always_ff @(posedge clock) begin
		if (buff_we) begin
			buff[wr_ptr] <= buff_wdata;
		end
	end

	ring_buff_ctrl ring_buff (
		.clock  (clock),
		.reset  (reset | abort),		// Abort drops anything buffered
		.we     (buff_we),
		.re     (buff_re),
		.wr_ptr (wr_ptr),
		.rd_ptr (rd_ptr),
		.full   (buff_full),
		.empty  (buff_empty),
		.num    (num)
	);

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (serv_state == SERV_INIT && cmd_strobe) begin
			stride_r  <= ext_in.data[WIDTH_ADDR-1:0];
			is_load_r <= ext_in.data[WIDTH_DATA-1];		// Operation bit
		end
		if (serv_state == SERV_LENGTH && cmd_strobe) begin
			length_r <= clip_length(ext_in.data[WIDTH_ADDR-1:0]);
		end
		if (serv_state == SERV_BASE && cmd_strobe) begin
			base_r <= ext_in.data[WIDTH_ADDR-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset || abort) begin
			serv_state <= SERV_INIT;
		end
		else begin
			case (serv_state)
				SERV_INIT:   serv_state <= cmd_strobe ? SERV_LENGTH : SERV_INIT;
				SERV_LENGTH: serv_state <= cmd_strobe ? SERV_BASE : SERV_LENGTH;
				SERV_BASE:   serv_state <= cmd_strobe ? SERV_RUN : SERV_BASE;
				SERV_RUN:    serv_state <= (st_done | ld_last) ? SERV_INIT : SERV_RUN;
				default:     serv_state <= SERV_INIT;
			endcase
		end
	end

	////////////////////////////////////////
	// Store and load control
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || abort) begin
			st_state <= ST_INIT;
		end
		else begin
			case (st_state)
				ST_INIT: st_state <= start_st ? ST_BUFF : ST_INIT;
				ST_BUFF: begin
					if (st_push && (num_ext + address_t'(1) == length_r)) begin
						st_state <= ST_REQ;			// Whole block buffered
					end
				end
				ST_REQ:  st_state <= grant ? ST_RUN : ST_REQ;
				ST_RUN:  st_state <= term ? ST_INIT : ST_RUN;
				default: st_state <= ST_INIT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset || abort) begin
			ld_state <= LD_INIT;
		end
		else begin
			case (ld_state)
				LD_INIT:  ld_state <= start_ld ? LD_WAIT : LD_INIT;
				LD_WAIT:  ld_state <= grant ? LD_RUN : LD_WAIT;
				LD_RUN:   ld_state <= term ? LD_DRAIN : LD_RUN;	// Last reads still in flight
				LD_DRAIN: ld_state <= ld_last ? LD_INIT : LD_DRAIN;
				default:  ld_state <= LD_INIT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_cnt <= '0;
		end
		else if (start_ld) begin
			ld_cnt <= '0;
		end
		else if (ld_pop) begin
			ld_cnt <= ld_cnt + address_t'(1);
		end
	end

	// One notify per store once half the block is in
	always_ff @(posedge clock) begin
		if (reset) begin
			notify_q <= 1'b0;
			notified <= 1'b0;
		end
		else begin
			notify_q <= 1'b0;
			if (start_st) begin
				notified <= 1'b0;
			end
			else if (!notified && !abort && (st_state == ST_BUFF || st_state == ST_REQ)
					&& num_ext == half_len) begin
				notify_q <= 1'b1;
				notified <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////
	assign cmd.req     = (st_state == ST_REQ) | (st_state == ST_RUN)
			| (ld_state == LD_WAIT) | (ld_state == LD_RUN);
	assign cmd.is_load = is_load_r;
	assign cmd.length  = length_r;
	assign cmd.stride  = stride_r;
	assign cmd.base    = base_r;
	assign st_data     = buff_rd;

	assign ext_out.req  = notify_q | ld_pop;
	assign ext_out.data = ld_pop ? buff_rd : (notify_q ? NOTIFY_DATA : '0);
	assign ext_out.rls  = ld_last;

	a_one_op: assert property (@(posedge clock) disable iff (reset)
			!(st_state != ST_INIT && ld_state != LD_INIT));

endmodule

`default_nettype wire

// File: extern_top.sv
/*
 * External-access subsystem top
 * Two port handlers sharing one data memory through the arbiter
 */
`timescale 1ns/1ps
`default_nettype none

module extern_top
	import pkg_extern::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire ext_in_t ext_in [NUM_PORTS],
	output ext_out_t ext_out [NUM_PORTS]
);

	access_cmd_t          cmd [NUM_PORTS];
	data_t                st_data [NUM_PORTS];
	logic [NUM_PORTS-1:0] grant;
	logic [NUM_PORTS-1:0] term;
	logic [NUM_PORTS-1:0] ld_valid;
	data_t                ld_data;
	logic                 mem_we;
	address_t             mem_addr;
	data_t                mem_wdata;
	data_t                mem_rdata;

	extern_handle handle0 (
		.clock (clock), .reset (reset),
		.ext_in (ext_in[0]), .ext_out (ext_out[0]),
		.cmd (cmd[0]), .grant (grant[0]), .term (term[0]),
		.st_data (st_data[0]), .ld_valid (ld_valid[0]), .ld_data (ld_data)
	);

	extern_handle handle1 (
		.clock (clock), .reset (reset),
		.ext_in (ext_in[1]), .ext_out (ext_out[1]),
		.cmd (cmd[1]), .grant (grant[1]), .term (term[1]),
		.st_data (st_data[1]), .ld_valid (ld_valid[1]), .ld_data (ld_data)
	);

	mem_access_arbiter arbiter (
		.clock (clock), .reset (reset),
		.cmd (cmd), .grant (grant), .term (term),
		.st_data (st_data), .ld_valid (ld_valid), .ld_data (ld_data),
		.mem_we (mem_we), .mem_addr (mem_addr),
		.mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
	);

	data_mem mem (
		.clock (clock), .we (mem_we), .addr (mem_addr),
		.wdata (mem_wdata), .rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// File: mem_access_arbiter.sv
/*
 * Data memory access arbiter
 * Round-robin grant to one handler, strided address generation
 * and a term pulse on the last beat
 */
`timescale 1ns/1ps
`default_nettype none

module mem_access_arbiter
	import pkg_extern::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire access_cmd_t cmd [NUM_PORTS],
	output logic [NUM_PORTS-1:0] grant,
	output logic [NUM_PORTS-1:0] term,
	input wire data_t st_data [NUM_PORTS],
	output logic [NUM_PORTS-1:0] ld_valid,
	output data_t ld_data,
	output logic mem_we,
	output address_t mem_addr,
	output data_t mem_wdata,
	input wire data_t mem_rdata
);

	logic [NUM_PORTS-1:0]  req_vec;
	logic [WIDTH_PORT-1:0] owner;		// Current or last served port
	logic [WIDTH_PORT-1:0] sel;
	logic                  busy;
	logic                  beat;
	logic                  last_beat;
	logic                  is_load_q;
	address_t              length_q;
	address_t              stride_q;
	address_t              addr_q;
	address_t              beat_cnt;

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			req_vec[i] = cmd[i].req;
		end
	end

	// Nearest requester after the last owner wins
	always_comb begin
		sel = owner;
		for (int i = NUM_PORTS; i >= 1; i--) begin
			if (req_vec[(int'(owner) + i) % NUM_PORTS]) begin
				sel = WIDTH_PORT'((int'(owner) + i) % NUM_PORTS);
			end
		end
	end

	assign beat      = busy & req_vec[owner];		// Falls when the owner aborts
	assign last_beat = (beat_cnt == length_q - address_t'(1));

	////////////////////////////////////////
	// Control
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			grant    <= '0;
			busy     <= 1'b0;
			owner    <= WIDTH_PORT'(NUM_PORTS - 1);
			ld_valid <= '0;
		end
		else begin
			grant    <= '0;
			ld_valid <= '0;
			if (beat && is_load_q) begin
				ld_valid[owner] <= 1'b1;			// Read data arrives next cycle
			end
			if (|grant) begin
				busy <= req_vec[owner];
			end
			else if (busy) begin
				if (!beat || last_beat) begin
					busy <= 1'b0;
				end
			end
			else if (|req_vec) begin
				grant[sel] <= 1'b1;
				owner      <= sel;
			end
		end
	end

	// Access parameters, latched with the grant
	always_ff @(posedge clock) begin
		if (!busy && !(|grant) && (|req_vec)) begin
			is_load_q <= cmd[sel].is_load;
			length_q  <= cmd[sel].length;
			stride_q  <= cmd[sel].stride;
			addr_q    <= cmd[sel].base;
			beat_cnt  <= '0;
		end
		else if (beat) begin
			addr_q   <= addr_q + stride_q;		// Wraps modulo MEM_DEPTH
			beat_cnt <= beat_cnt + address_t'(1);
		end
	end

	////////////////////////////////////////
	// Memory side
	////////////////////////////////////////
	always_comb begin
		term        = '0;
		term[owner] = beat & last_beat;
	end

	assign mem_we    = beat & ~is_load_q;
	assign mem_addr  = addr_q;
	assign mem_wdata = st_data[owner];
	assign ld_data   = mem_rdata;

	a_grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant));
	// Term closes a running access
	a_term_running: assert property (@(posedge clock) disable iff (reset)
			|term |-> busy ##1 !busy);

endmodule

`default_nettype wire

// File: pkg_extern.sv
/*
 * Shared definitions for the external-access subsystem.
 * Sizes, port bundles, the memory access command and FSM encodings.
 */
`default_nettype none

package pkg_extern;

	////////////////////////////////////////
	// Sizes
	////////////////////////////////////////
	localparam int WIDTH_DATA = 32;
	localparam int WIDTH_ADDR = 10;
	localparam int MEM_DEPTH  = 1024;			// 2**WIDTH_ADDR, addresses wrap naturally
	localparam int BUFF_SIZE  = 16;
	localparam int WIDTH_BUFF = $clog2(BUFF_SIZE);
	localparam int NUM_PORTS  = 2;
	localparam int WIDTH_PORT = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

	typedef logic [WIDTH_DATA-1:0] data_t;
	typedef logic [WIDTH_ADDR-1:0] address_t;

	localparam data_t NOTIFY_DATA = '1;		// Half-block notification word

	////////////////////////////////////////
	// Bundles
	////////////////////////////////////////
	typedef struct packed {
		logic  req;							// Word strobe
		data_t data;
		logic  rls;							// Release, aborts the transaction
	} ext_in_t;

	typedef struct packed {
		logic  req;
		data_t data;
		logic  rls;							// Marks the last loaded word
	} ext_out_t;

	typedef struct packed {
		logic     req;						// Level, held until term
		logic     is_load;
		address_t length;
		address_t stride;
		address_t base;
	} access_cmd_t;

	// Handler state machines
	typedef enum logic [1:0] {SERV_INIT, SERV_LENGTH, SERV_BASE, SERV_RUN} fsm_serv_t;
	typedef enum logic [1:0] {ST_INIT, ST_BUFF, ST_REQ, ST_RUN} fsm_st_t;
	typedef enum logic [1:0] {LD_INIT, LD_WAIT, LD_RUN, LD_DRAIN} fsm_ld_t;

endpackage

`default_nettype wire

// File: ring_buff_ctrl.sv
/*
 * Ring buffer controller
 * Wrapping write and read pointers with an occupancy count
 */
`timescale 1ns/1ps
`default_nettype none

module ring_buff_ctrl
	import pkg_extern::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic we,
	input wire logic re,
	output logic [WIDTH_BUFF-1:0] wr_ptr,
	output logic [WIDTH_BUFF-1:0] rd_ptr,
	output logic full,
	output logic empty,
	output logic [WIDTH_BUFF:0] num
);

	// Pointers wrap at BUFF_SIZE since it is a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else begin
			if (we) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (re) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			num <= '0;
		end
		else begin
			case ({we, re})
				2'b10:   num <= num + 1'b1;
				2'b01:   num <= num - 1'b1;
				default: num <= num;			// Both or neither
			endcase
		end
	end

	assign full  = (num == (WIDTH_BUFF+1)'(BUFF_SIZE));
	assign empty = (num == '0);

	a_no_overflow: assert property (@(posedge clock) disable iff (reset) we |-> !full || re);
	a_no_underflow: assert property (@(posedge clock) disable iff (reset) re |-> !empty);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_extern_top -f build.f -o tb_extern_top

./obj_dir/tb_extern_top | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// File: tb_extern_top.sv
/*
 * Testbench for the external-access subsystem
 * Table-driven stores and loads on both ports against a reference memory
 */
`timescale 1ns/1ps
`default_nettype none

module tb_extern_top
	import pkg_extern::*;
();

	localparam int TIMEOUT = 300;		// Cycles per wait
	localparam int NUM_TXN = 13;

	typedef struct packed {
		logic       par;				// Runs together with the next entry
		logic       port;
		logic       is_load;
		address_t   stride;
		address_t   length;
		address_t   base;
		logic [4:0] abort_after;		// Words sent before rls, 0 for none
	} txn_t;

	localparam txn_t TXNS [NUM_TXN] = '{
		'{1'b0, 1'b0, 1'b0, 10'd1,   10'd8,  10'd16,  5'd0},
		'{1'b0, 1'b0, 1'b1, 10'd1,   10'd8,  10'd16,  5'd0},
		'{1'b1, 1'b0, 1'b0, 10'd3,   10'd10, 10'd100, 5'd0},	// Both ports at once
		'{1'b0, 1'b1, 1'b0, 10'd2,   10'd12, 10'd200, 5'd0},
		'{1'b0, 1'b0, 1'b1, 10'd3,   10'd10, 10'd100, 5'd0},
		'{1'b0, 1'b1, 1'b1, 10'd2,   10'd12, 10'd200, 5'd0},
		'{1'b0, 1'b1, 1'b0, 10'd1,   10'd6,  10'd300, 5'd0},
		'{1'b0, 1'b1, 1'b0, 10'd1,   10'd6,  10'd300, 5'd4},	// Aborted
		'{1'b0, 1'b1, 1'b1, 10'd1,   10'd6,  10'd300, 5'd0},
		'{1'b0, 1'b0, 1'b0, 10'd300, 10'd7,  10'd900, 5'd0},	// Wraps past MEM_DEPTH
		'{1'b0, 1'b0, 1'b1, 10'd300, 10'd7,  10'd900, 5'd0},
		'{1'b0, 1'b1, 1'b0, 10'd5,   10'd16, 10'd500, 5'd0},
		'{1'b0, 1'b0, 1'b1, 10'd5,   10'd16, 10'd500, 5'd0}
	};

	logic     clock;
	logic     reset;
	ext_in_t  ext_in [NUM_PORTS];
	ext_out_t ext_out [NUM_PORTS];

	data_t    model [MEM_DEPTH];		// Reference memory
	ext_out_t rx0 [$];
	ext_out_t rx1 [$];
	data_t    lfsr_state;
	int       checks;
	int       errors;
	int       timeouts;
	logic     hung;

	extern_top dut0 (
		.clock   (clock),
		.reset   (reset),
		.ext_in  (ext_in),
		.ext_out (ext_out)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Port output monitor
	always @(negedge clock) begin
		if (!reset) begin
			if (ext_out[0].req || ext_out[0].rls) begin
				rx0.push_back(ext_out[0]);
			end
			if (ext_out[1].req || ext_out[1].rls) begin
				rx1.push_back(ext_out[1]);
			end
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic data_t lfsr_next(input data_t s);
		data_t n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	// One LFSR step per bit
	function automatic data_t rand_word();
		data_t w;
		int    b;
		w = '0;
		for (b = 0; b < WIDTH_DATA; b++) begin
			w = {w[WIDTH_DATA-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return w;
	endfunction

	function automatic int rx_size(input int p);
		if (p == 0) begin
			return rx0.size();
		end
		return rx1.size();
	endfunction

	function automatic ext_out_t rx_pop(input int p);
		if (p == 0) begin
			return rx0.pop_front();
		end
		return rx1.pop_front();
	endfunction

	function automatic void rx_clear(input int p);
		if (p == 0) begin
			rx0.delete();
		end
		else begin
			rx1.delete();
		end
	endfunction

	function automatic logic last_seen(input int p);
		if (rx_size(p) == 0) begin
			return 1'b0;
		end
		return (p == 0) ? rx0[$].rls : rx1[$].rls;
	endfunction

	function automatic logic mem_req(input int p);
		return dut0.cmd[p].req;		// Held by the handler until term
	endfunction

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic check_value(input string what, input data_t got, input data_t exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input int p, input string what);
		$display("Timeout at %0t ns: port %0d never %s", $time, p, what);
		timeouts++;
		hung = 1'b1;
	endtask

	////////////////////////////////////////
	// Port drivers
	////////////////////////////////////////
	task automatic send_word(input int p, input data_t w);
		ext_in[p].req  = 1'b1;
		ext_in[p].data = w;
		ext_in[p].rls  = 1'b0;
		step();
	endtask

	task automatic send_cmd(input int p, input txn_t t);
		send_word(p, {t.is_load, 21'd0, t.stride});
		send_word(p, data_t'(t.length));
		send_word(p, data_t'(t.base));
	endtask

	task automatic run_store(input txn_t t);
		data_t    words [BUFF_SIZE];
		int       p;
		int       n;
		int       i;
		int       wait_cnt;
		ext_out_t e;
		p = int'(t.port);
		for (i = 0; i < int'(t.length); i++) begin
			words[i] = rand_word();
		end
		n = (t.abort_after != '0) ? int'(t.abort_after) : int'(t.length);
		rx_clear(p);
		send_cmd(p, t);
		for (i = 0; i < n; i++) begin
			send_word(p, words[i]);
		end
		ext_in[p] = '0;
		if (t.abort_after != '0) begin
			ext_in[p].rls = 1'b1;
			step();
			ext_in[p] = '0;
			repeat (2) step();
			rx_clear(p);				// Notify may have come before the abort
			return;
		end
		wait_cnt = 0;
		while (!mem_req(p) && wait_cnt < TIMEOUT) begin
			step();
			wait_cnt++;
		end
		if (!mem_req(p)) begin
			report_timeout(p, "requested the memory for a store");
			return;
		end
		wait_cnt = 0;
		while (mem_req(p) && wait_cnt < TIMEOUT) begin
			step();
			wait_cnt++;
		end
		if (mem_req(p)) begin
			report_timeout(p, "finished writing a store");
			return;
		end
		step();
		check_value($sformatf("port %0d notify count", p), data_t'(rx_size(p)), data_t'(1));
		if (rx_size(p) > 0) begin
			e = rx_pop(p);
			check_value($sformatf("port %0d notify word", p), e.data, NOTIFY_DATA);
			check_value($sformatf("port %0d notify rls", p), data_t'(e.rls), '0);
		end
		for (i = 0; i < int'(t.length); i++) begin
			model[(int'(t.base) + i * int'(t.stride)) % MEM_DEPTH] = words[i];
		end
	endtask

	task automatic run_load(input txn_t t);
		int       p;
		int       i;
		int       addr;
		int       wait_cnt;
		ext_out_t e;
		p = int'(t.port);
		rx_clear(p);
		send_cmd(p, t);
		ext_in[p] = '0;
		wait_cnt = 0;
		while (!last_seen(p) && wait_cnt < TIMEOUT) begin
			step();
			wait_cnt++;
		end
		if (!last_seen(p)) begin
			report_timeout(p, "returned the last loaded word");
			return;
		end
		repeat (2) step();				// Stray words would show up here
		check_value($sformatf("port %0d load word count", p),
				data_t'(rx_size(p)), data_t'(t.length));
		for (i = 0; i < int'(t.length) && rx_size(p) > 0; i++) begin
			e = rx_pop(p);
			addr = (int'(t.base) + i * int'(t.stride)) % MEM_DEPTH;
			check_value($sformatf("port %0d load word %0d at %0d", p, i, addr),
					e.data, model[addr]);
			check_value($sformatf("port %0d rls on word %0d", p, i),
					data_t'(e.rls), data_t'(i == int'(t.length) - 1));
		end
	endtask

	task automatic run_txn(input txn_t t);
		if (t.is_load) begin
			run_load(t);
		end
		else begin
			run_store(t);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		int i;
		int k;
		for (i = 0; i < NUM_PORTS; i++) begin
			ext_in[i] = '0;
		end
		reset      = 1'b1;
		lfsr_state = 32'd42;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		hung       = 1'b0;
		repeat (5) @(posedge clock);
		#2 reset = 1'b0;

		// Quiet ports after reset
		for (k = 0; k < 4; k++) begin
			step();
			for (i = 0; i < NUM_PORTS; i++) begin
				check_value($sformatf("port %0d idle req", i), data_t'(ext_out[i].req), '0);
				check_value($sformatf("port %0d idle rls", i), data_t'(ext_out[i].rls), '0);
			end
		end
		check_value("words seen while idle", data_t'(rx_size(0) + rx_size(1)), '0);

		i = 0;
		while (i < NUM_TXN && !hung) begin
			if (TXNS[i].par && i + 1 < NUM_TXN) begin
				fork
					run_txn(TXNS[i]);
					run_txn(TXNS[i+1]);
				join
				i += 2;
			end
			else begin
				run_txn(TXNS[i]);
				i++;
			end
			step();
		end

		$display("Summary: %0d checks, %0d check errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end
		else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
